// File: all.f
+incdir+verilog
verilog/fp16_pkg.sv
verilog/fma_pkg.sv
verilog/fp16_unpack.sv
verilog/fma_multiply_align.sv
verilog/fma_normalize_pack.sv
verilog/fp16_fma_top.sv
sim/fp16_fma_assertions.sv
sim/fp16_fma_tb.sv

// File: Makefile
TOP = fp16_fma_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/fp16_fma_tb.sv
//--------------------
// Testbench for the half precision FMA
// Vector table, random special values,
// valid gating and error count
//--------------------

`timescale 1ns/1ns
`default_nettype none
`include "fp16_defines.svh"

module fp16_fma_tb;

    typedef struct packed {
        fp16_pkg::fp16_t a;
        fp16_pkg::fp16_t b;
        fp16_pkg::fp16_t c;
        fp16_pkg::fp16_t expected;
    } vector_t;

    localparam int NUM_VECTORS   = 19;
    localparam int NUM_RANDOM    = 48;
    localparam int DRAIN_TIMEOUT = 20;      // Cycles

    //--------------------
    // a, b, c, expected
    //--------------------
    localparam vector_t VECTORS [NUM_VECTORS] = '{
        {16'h3e00, 16'h4000, 16'h3400, 16'h4280},   // 1.5 * 2 + 0.25 = 3.25
        {16'h3f00, 16'h3f00, 16'h3c00, 16'h4410},   // Product carry, 4.0625
        {16'h3c01, 16'h3c01, 16'h3c00, 16'h4001},   // 2^-21 dropped
        {16'h7bff, 16'h3c00, 16'h3c00, 16'h7bff},   // 65505 truncates to max
        {16'h3e00, 16'h3c00, 16'hbf00, 16'hb400},   // Same exponent, c larger
        {16'h4000, 16'h4000, 16'hc400, 16'h0000},   // Exact cancellation
        {16'h5c00, 16'h5c00, 16'h0000, 16'h7c00},   // 65536 overflows
        {16'hdc00, 16'h5c00, 16'h0000, 16'hfc00},
        {16'h1c01, 16'h1c01, 16'h0000, 16'h0100},   // Subnormal, not rounded up
        {16'h1c00, 16'h1c00, 16'h0001, 16'h0101},
        {16'h9c00, 16'h1c00, 16'h0000, 16'h8100},
        {16'h7c01, 16'h3c00, 16'h3c00, `FP16_QNAN},
        {16'h7c00, 16'h0000, 16'h3c00, `FP16_QNAN},  // inf * 0
        {16'h7c00, 16'h3c00, 16'hfc00, `FP16_QNAN},  // inf - inf
        {16'h7c00, 16'hc000, 16'h3c00, 16'hfc00},
        {16'h3c00, 16'h3c00, 16'hfc00, 16'hfc00},
        {16'h0000, 16'h3c00, 16'h8123, 16'h8123},   // Zero product returns c
        {16'h8000, 16'h3c00, 16'h8000, 16'h8000},
        {16'h3c00, 16'h3c00, 16'h7d55, `FP16_QNAN}
    };

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    fp16_pkg::fp16_t a;
    fp16_pkg::fp16_t b;
    fp16_pkg::fp16_t c;
    fp16_pkg::fp16_t result;
    logic            out_valid;

    fp16_pkg::fp16_t expected_q [$];
    int              errors;
    int              checks;
    logic [31:0]     rng_state;

    fp16_fma_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .c         (c),
        .result    (result),
        .out_valid (out_valid)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Only for operand sets where a NaN, infinity or zero product decides the result
    function automatic fp16_pkg::fp16_t special_result(input fp16_pkg::fp16_t op_a,
                                                       input fp16_pkg::fp16_t op_b,
                                                       input fp16_pkg::fp16_t op_c);
        logic a_nan;
        logic b_nan;
        logic c_nan;
        logic a_inf;
        logic b_inf;
        logic c_inf;
        logic a_zero;
        logic b_zero;
        logic prod_sign;
        a_nan     = (op_a.exp == 5'h1f) && (op_a.frac != '0);
        b_nan     = (op_b.exp == 5'h1f) && (op_b.frac != '0);
        c_nan     = (op_c.exp == 5'h1f) && (op_c.frac != '0);
        a_inf     = (op_a.exp == 5'h1f) && (op_a.frac == '0);
        b_inf     = (op_b.exp == 5'h1f) && (op_b.frac == '0);
        c_inf     = (op_c.exp == 5'h1f) && (op_c.frac == '0);
        a_zero    = (op_a.exp == '0) && (op_a.frac == '0);
        b_zero    = (op_b.exp == '0) && (op_b.frac == '0);
        prod_sign = op_a.sign ^ op_b.sign;
        if (a_nan || b_nan || c_nan) begin
            return `FP16_QNAN;
        end
        if ((a_inf && b_zero) || (a_zero && b_inf)) begin
            return `FP16_QNAN;
        end
        if ((a_inf || b_inf) && c_inf && (prod_sign != op_c.sign)) begin
            return `FP16_QNAN;
        end
        if (a_inf || b_inf) begin
            return {prod_sign, 5'h1f, 10'h000};
        end
        return op_c;                                    // Infinite c or zero product
    endfunction

    task automatic drive(input fp16_pkg::fp16_t va, input fp16_pkg::fp16_t vb,
                         input fp16_pkg::fp16_t vc, input logic valid);
        @(negedge clk);
        a        = va;
        b        = vb;
        c        = vc;
        in_valid = valid;
    endtask

    //--------------------
    // Result checker
    //--------------------
    always @(negedge clk) begin : check_results
        fp16_pkg::fp16_t exp_val;
        if (!rst_n) begin
            assert (out_valid === 1'b0) else begin
                $display("FAILED at %0t ns: out_valid expected 0, got %b", $time, out_valid);
                errors++;
            end
            assert (result === `FP16_ZERO) else begin
                $display("FAILED at %0t ns: result expected %h, got %h",
                         $time, `FP16_ZERO, result);
                errors++;
            end
        end else if (out_valid) begin
            assert (expected_q.size() > 0) else begin
                $display("Result came out at %0t ns with no valid input pending", $time);
                errors++;
            end
            if (expected_q.size() > 0) begin
                exp_val = expected_q.pop_front();
                checks++;
                assert (result === exp_val) else begin
                    $display("FAILED at %0t ns: result expected %h, got %h",
                             $time, exp_val, result);
                    errors++;
                end
            end
        end
    end

    initial begin
        fp16_pkg::fp16_t ra;
        fp16_pkg::fp16_t rb;
        fp16_pkg::fp16_t rc;
        int              mode;
        int              gap;
        int              wait_cycles;
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        a         = '0;
        b         = '0;
        c         = '0;
        ra        = '0;
        rb        = '0;
        rc        = '0;
        errors    = 0;
        checks    = 0;
        rng_state = 32'hda459d58;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Table back to back
        for (int i = 0; i < NUM_VECTORS; i++) begin
            drive(VECTORS[i].a, VECTORS[i].b, VECTORS[i].c, 1'b1);
            expected_q.push_back(VECTORS[i].expected);
        end

        // Random special values, idle gaps between some of them
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng_state = xorshift32(rng_state);
            ra        = rng_state[15:0];
            rb        = rng_state[31:16];
            rng_state = xorshift32(rng_state);
            rc        = rng_state[15:0];
            mode      = int'(rng_state[23:16]) % 5;
            gap       = int'(rng_state[25:24]);
            case (mode)
                0: ra = {ra.sign, 5'h1f, ra.frac | 10'h001};
                1: rb = {rb.sign, 5'h1f, rb.frac | 10'h001};
                2: rc = {rc.sign, 5'h1f, rc.frac | 10'h001};
                3: ra = {ra.sign, 15'h0000};
                default: rb = {rb.sign, 15'h0000};
            endcase
            drive(ra, rb, rc, 1'b1);
            expected_q.push_back(special_result(ra, rb, rc));
            for (int g = 0; g < gap; g++) begin
                drive(rc, ra, rb, 1'b0);                // Operands change, valid low
            end
        end
        drive(ra, rb, rc, 1'b0);

        wait_cycles = 0;
        while (expected_q.size() > 0 && wait_cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        assert (expected_q.size() == 0) else begin
            $display("Timed out with %0d results never delivered", expected_q.size());
            errors++;
        end
        repeat (`FMA_LATENCY) @(negedge clk);          // Quiet window for stray results

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, UUT.u_assertions.failures);
        if (errors == 0 && UUT.u_assertions.failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/fp16_fma_assertions.sv
//--------------------
// Bound FMA checker
// Valid latency, reset and NaN form
//--------------------

`timescale 1ns/1ns
`default_nettype none
`include "fp16_defines.svh"

module fp16_fma_assertions (
    input logic            clk,
    input logic            rst_n,
    input logic            in_valid,
    input fp16_pkg::fp16_t result,
    input logic            out_valid
);

    int unsigned failures = 0;          // Failed assertion count

    // Sampled at edge N, out_valid set after edge N+3, seen at edge N+4
    assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n, `FMA_LATENCY) |-> (out_valid == $past(in_valid, `FMA_LATENCY)))
        else begin
            $error("out_valid does not follow in_valid by the pipeline latency");
            failures++;
        end

    assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            $error("out_valid high while in reset");
            failures++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && result.exp == `FP16_EXP_MAX && result.frac != '0) |->
        (result == `FP16_QNAN))
        else begin
            $error("NaN result is not the canonical NaN");
            failures++;
        end

endmodule

bind fp16_fma_top fp16_fma_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .result    (result),
    .out_valid (out_valid)
);

`default_nettype wire

// File: verilog/fp16_fma_top.sv
//--------------------
// Half precision FMA top
// result = a * b + c over four register stages
//--------------------

`timescale 1ns/1ns
`default_nettype none

module fp16_fma_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  fp16_pkg::fp16_t a,
    input  fp16_pkg::fp16_t b,
    input  fp16_pkg::fp16_t c,
    output fp16_pkg::fp16_t result,
    output logic            out_valid
);

    fma_pkg::unpacked_t stage;
    logic               stage_valid;
    fma_pkg::sum_t      sum;
    logic               sum_valid;

    fp16_unpack u_unpack (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .a           (a),
        .b           (b),
        .c           (c),
        .stage       (stage),
        .stage_valid (stage_valid)
    );

    // Stages 2 and 3
    fma_multiply_align u_multiply_align (
        .clk         (clk),
        .rst_n       (rst_n),
        .stage       (stage),
        .stage_valid (stage_valid),
        .sum         (sum),
        .sum_valid   (sum_valid)
    );

    fma_normalize_pack u_normalize_pack (
        .clk       (clk),
        .rst_n     (rst_n),
        .sum       (sum),
        .sum_valid (sum_valid),
        .result    (result),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

// File: verilog/fma_normalize_pack.sv
//--------------------
// FMA stage 4
// Leading one normalization, truncation,
// overflow and subnormal packing
//--------------------

`timescale 1ns/1ns
`default_nettype none
`include "fp16_defines.svh"

module fma_normalize_pack (
    input  logic            clk,
    input  logic            rst_n,
    input  fma_pkg::sum_t   sum,
    input  logic            sum_valid,
    output fp16_pkg::fp16_t result,
    output logic            out_valid
);

    fma_pkg::special_payload_t spec;
    logic [5:0]                lead;
    logic [47:0]               mag;
    logic signed [8:0]         exp_n;
    logic [8:0]                sub_shift;
    fp16_pkg::fp16_t           packed_res;

    always_comb begin
        spec  = sum.mag;
        mag   = sum.mag;
        exp_n = 9'(sum.exp);                                // Sign extended
        lead  = '0;
        for (int i = 0; i < 48; i++) begin
            if (mag[i]) begin
                lead = 6'(i);
            end
        end

        if (mag[47]) begin                                  // Adder carry
            mag   = mag >> 1;
            exp_n = exp_n + 9'sd1;
        end else begin
            mag   = mag << (6'd46 - lead);
            exp_n = exp_n - 9'(6'd46 - lead);
        end

        // Pack, dropped bits truncate toward zero
        sub_shift       = '0;
        packed_res.sign = sum.sign;
        packed_res.exp  = exp_n[4:0];
        packed_res.frac = mag[45:36];
        if (mag == '0) begin
            packed_res = `FP16_ZERO;                        // Exact cancellation
        end else if (exp_n >= 9'sd31) begin
            packed_res.exp  = `FP16_EXP_MAX;
            packed_res.frac = '0;
        end else if (exp_n <= 9'sd0) begin
            sub_shift       = 9'(9'sd1 - exp_n);
            packed_res.exp  = '0;
            packed_res.frac = 10'(mag[46:36] >> sub_shift);
        end

        if (sum.special) begin
            case (spec.kind)
                fma_pkg::SPEC_NAN: packed_res = `FP16_QNAN;
                fma_pkg::SPEC_INF: packed_res = {sum.sign, `FP16_EXP_MAX, 10'b0};
                default:           packed_res = {sum.sign, spec.exp, spec.frac};
            endcase
        end
    end

    //--------------------
    // Result register
    //--------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result    <= `FP16_ZERO;
            out_valid <= 1'b0;
        end else begin
            result    <= packed_res;
            out_valid <= sum_valid;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fma_multiply_align.sv
//--------------------
// FMA stages 2 and 3
// Significand product, special case priority,
// alignment and magnitude add or subtract
//--------------------

`timescale 1ns/1ns
`default_nettype none

module fma_multiply_align (
    input  logic               clk,
    input  logic               rst_n,
    input  fma_pkg::unpacked_t stage,
    input  logic               stage_valid,
    output fma_pkg::sum_t      sum,
    output logic               sum_valid
);

    localparam logic signed [6:0] ZERO_C_EXP = 7'h40;  // -64, below any product

    logic [21:0]               product;
    logic [4:0]                prod_lead;
    logic [21:0]               prod_norm;
    logic signed [6:0]         prod_exp;
    logic [10:0]               c_sig;
    logic [3:0]                c_lead;
    logic [10:0]               c_norm;
    logic signed [6:0]         c_exp;
    logic                      special;
    fma_pkg::special_kind_t    kind;

    logic [21:0]               s2_prod_mant;
    logic signed [6:0]         s2_prod_exp;
    logic                      s2_prod_sign;
    logic [10:0]               s2_c_mant;
    logic signed [6:0]         s2_c_exp;
    fp16_pkg::fp16_t           s2_c;
    logic                      s2_special;
    fma_pkg::special_kind_t    s2_kind;
    logic                      s2_valid;

    logic [47:0]               prod_field;
    logic [47:0]               c_field;
    logic [47:0]               big_field;
    logic [47:0]               small_field;
    logic                      prod_bigger;
    logic [7:0]                exp_diff;
    fma_pkg::special_payload_t spec;
    fma_pkg::sum_t             next_sum;

    //--------------------
    // Stage 2
    //--------------------
    always_comb begin
        product   = stage.sig_a * stage.sig_b;
        prod_lead = '0;
        for (int i = 0; i < 22; i++) begin
            if (product[i]) begin
                prod_lead = 5'(i);
            end
        end
        prod_norm = product << (5'd21 - prod_lead);         // Leading one to bit 21
        prod_exp  = stage.exp_sum + 7'(prod_lead) - 7'd20;

        // Addend normalized too, so magnitudes compare by exponent first
        c_sig  = {stage.c.exp != '0, stage.c.frac};
        c_lead = '0;
        for (int j = 0; j < 11; j++) begin
            if (c_sig[j]) begin
                c_lead = 4'(j);
            end
        end
        c_norm = c_sig << (4'd10 - c_lead);
        if (stage.c_class.is_zero) begin
            c_exp = ZERO_C_EXP;
        end else begin
            c_exp = ((stage.c.exp == '0) ? 7'd1 : {2'b00, stage.c.exp}) + 7'(c_lead) - 7'd10;
        end

        // Special priority, NaN first
        special = 1'b1;
        kind    = fma_pkg::SPEC_PASS_C;
        if (stage.prod_special == fma_pkg::PROD_NAN || stage.c_class.is_nan) begin
            kind = fma_pkg::SPEC_NAN;
        end else if (stage.prod_special == fma_pkg::PROD_INF && stage.c_class.is_inf &&
                     stage.sign != stage.c.sign) begin
            kind = fma_pkg::SPEC_NAN;                       // inf - inf
        end else if (stage.prod_special == fma_pkg::PROD_INF) begin
            kind = fma_pkg::SPEC_INF;
        end else if (!stage.c_class.is_inf && stage.prod_special != fma_pkg::PROD_ZERO) begin
            special = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        s2_prod_mant <= prod_norm;
        s2_prod_exp  <= prod_exp;
        s2_prod_sign <= stage.sign;
        s2_c_mant    <= c_norm;
        s2_c_exp     <= c_exp;
        s2_c         <= stage.c;
        s2_special   <= special;
        s2_kind      <= kind;
    end

    //--------------------
    // Stage 3
    //--------------------
    always_comb begin
        prod_field  = {1'b0, s2_prod_mant, 25'b0};          // Bit 47 left for the carry
        c_field     = {1'b0, s2_c_mant, 36'b0};
        prod_bigger = (s2_prod_exp > s2_c_exp) ||
                      ((s2_prod_exp == s2_c_exp) && (prod_field >= c_field));

        if (prod_bigger) begin
            exp_diff      = 8'(s2_prod_exp) - 8'(s2_c_exp);
            big_field     = prod_field;
            small_field   = c_field >> exp_diff;
            next_sum.exp  = s2_prod_exp;
            next_sum.sign = s2_prod_sign;
        end else begin
            exp_diff      = 8'(s2_c_exp) - 8'(s2_prod_exp);
            big_field     = c_field;
            small_field   = prod_field >> exp_diff;
            next_sum.exp  = s2_c_exp;
            next_sum.sign = s2_c.sign;
        end

        if (s2_prod_sign == s2_c.sign) begin
            next_sum.mag = big_field + small_field;
        end else begin
            next_sum.mag = big_field - small_field;         // Never negative
        end
        next_sum.special = s2_special;

        spec.pad  = '0;
        spec.kind = s2_kind;
        spec.exp  = s2_c.exp;
        spec.frac = s2_c.frac;
        if (s2_special) begin
            next_sum.sign = (s2_kind == fma_pkg::SPEC_INF) ? s2_prod_sign : s2_c.sign;
            next_sum.mag  = spec;
            next_sum.exp  = '0;
        end
    end

    always_ff @(posedge clk) begin
        sum <= next_sum;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid  <= 1'b0;
            sum_valid <= 1'b0;
        end else begin
            s2_valid  <= stage_valid;
            sum_valid <= s2_valid;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fp16_unpack.sv
//--------------------
// FMA stage 1
// Operand classification, hidden bit restore,
// product exponent and product special code
//--------------------

`timescale 1ns/1ns
`default_nettype none
`include "fp16_defines.svh"

module fp16_unpack (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  fp16_pkg::fp16_t    a,
    input  fp16_pkg::fp16_t    b,
    input  fp16_pkg::fp16_t    c,
    output fma_pkg::unpacked_t stage,
    output logic               stage_valid
);

    fp16_pkg::fp16_class_t cls_a;
    fp16_pkg::fp16_class_t cls_b;
    logic [6:0]            eff_exp_a;
    logic [6:0]            eff_exp_b;
    fma_pkg::unpacked_t    next_stage;

    function automatic fp16_pkg::fp16_class_t classify(input fp16_pkg::fp16_t x);
        fp16_pkg::fp16_class_t k;
        k.is_nan  = (x.exp == `FP16_EXP_MAX) && (x.frac != '0);
        k.is_inf  = (x.exp == `FP16_EXP_MAX) && (x.frac == '0);
        k.is_zero = (x.exp == '0) && (x.frac == '0);
        return k;
    endfunction

    always_comb begin
        cls_a     = classify(a);
        cls_b     = classify(b);
        eff_exp_a = (a.exp == '0) ? 7'd1 : {2'b00, a.exp};    // Subnormals use exponent 1
        eff_exp_b = (b.exp == '0) ? 7'd1 : {2'b00, b.exp};

        next_stage.exp_sum = eff_exp_a + eff_exp_b - 7'(`FP16_BIAS);
        next_stage.sign    = a.sign ^ b.sign;
        next_stage.sig_a   = {a.exp != '0, a.frac};
        next_stage.sig_b   = {b.exp != '0, b.frac};
        next_stage.c_class = classify(c);
        next_stage.c       = c;

        // inf x 0 is folded into the NaN code here
        if (cls_a.is_nan || cls_b.is_nan || (cls_a.is_inf && cls_b.is_zero) ||
            (cls_a.is_zero && cls_b.is_inf)) begin
            next_stage.prod_special = fma_pkg::PROD_NAN;
        end else if (cls_a.is_inf || cls_b.is_inf) begin
            next_stage.prod_special = fma_pkg::PROD_INF;
        end else if (cls_a.is_zero || cls_b.is_zero) begin
            next_stage.prod_special = fma_pkg::PROD_ZERO;
        end else begin
            next_stage.prod_special = fma_pkg::PROD_NONE;
        end
    end

    always_ff @(posedge clk) begin
        stage <= next_stage;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= in_valid;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fma_pkg.sv
//--------------------
// FMA pipeline payloads
// Stage 1 unpacked operands, stage 3 aligned sum
// and the special result code carried in the sum
//--------------------

`default_nettype none

package fma_pkg;

    // Product class decided in stage 1
    typedef enum logic [1:0] {PROD_NONE, PROD_NAN, PROD_INF, PROD_ZERO} prod_special_t;

    // Special result rebuilt by the output stage
    typedef enum logic [1:0] {SPEC_NAN, SPEC_INF, SPEC_PASS_C} special_kind_t;

    typedef struct packed {
        logic signed [6:0]     exp_sum;     // Product exponent, bias removed once
        logic                  sign;        // Product sign
        logic [10:0]           sig_a;       // Significands with hidden bit
        logic [10:0]           sig_b;
        fp16_pkg::fp16_class_t c_class;
        fp16_pkg::fp16_t       c;
        prod_special_t         prod_special;
    } unpacked_t;

    typedef struct packed {
        logic signed [6:0] exp;             // Exponent of the larger operand
        logic              sign;
        logic [47:0]       mag;             // Binary point after bit 46
        logic              special;
    } sum_t;

    // Layout of sum_t.mag when special is set
    typedef struct packed {
        logic [30:0]   pad;
        special_kind_t kind;
        logic [4:0]    exp;                 // c fields for pass-through
        logic [9:0]    frac;
    } special_payload_t;

endpackage

`default_nettype wire

// File: verilog/fp16_pkg.sv
//--------------------
// Binary16 number format
// Operand layout and operand class flags
//--------------------

`default_nettype none

package fp16_pkg;

    //--------------------
    // IEEE 754 half precision word
    //--------------------
    typedef struct packed {
        logic       sign;
        logic [4:0] exp;        // Biased exponent
        logic [9:0] frac;       // Fraction without hidden bit
    } fp16_t;

    //--------------------
    // Operand class
    //--------------------
    typedef struct packed {
        logic is_nan;
        logic is_inf;
        logic is_zero;
    } fp16_class_t;

endpackage

`default_nettype wire

// File: verilog/fp16_defines.svh
//--------------------
// Binary16 constants, exponent bias
// and FMA pipeline latency macros
//--------------------

`ifndef FP16_DEFINES_SVH
`define FP16_DEFINES_SVH

// Positive zero
`define FP16_ZERO       16'h0000

// Canonical quiet NaN, the only NaN the unit produces
`define FP16_QNAN       16'h7e00

// Exponent field of infinities and NaNs
`define FP16_EXP_MAX    5'h1f

`define FP16_BIAS       15          // Binary16 exponent bias

// Clock edges from operand capture to result, input register included
`define FMA_LATENCY     4

`endif
